// File: Makefile
# Verilator build and run of the rename stage testbench.
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = rename_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build, run, then judge the run by its log.
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "No verdict in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/rename_assert.sv
// Concurrent checks on the free list of the rename stage.
// Bound into free_list, where the pop and push strobes and the count live.
// Push there is the retire strobe of the retirement map.
`timescale 1ns/1ps

module rename_assert (
  input logic                                     clk,
  input logic                                     rst,
  input logic                                     alloc_i,    // Pop strobe.
  input logic                                     retire_i,   // Push strobe.
  input logic                                     recover_i,
  input logic [$clog2(rename_pkg::FREE_DEPTH):0]  count_i
);

  // A pop needs a name in the list.
  a_no_alloc_empty: assert property (@(posedge clk) disable iff (rst)
    alloc_i |-> (count_i != '0))
    else $error("allocation while the free list is empty");

  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count_i <= rename_pkg::FREE_DEPTH)
    else $error("free list count above its depth");

  // Recovery rewinds the head, which a push in the same cycle would upset.
  a_retire_recover: assert property (@(posedge clk) disable iff (rst)
    !(retire_i && recover_i))
    else $error("retire and recover high together");

endmodule

bind free_list rename_assert u_rename_assert (
  .clk       (clk),
  .rst       (rst),
  .alloc_i   (pop),
  .retire_i  (push),
  .recover_i (recover_i),
  .count_i   (count_q)
);

// File: bench/rename_tb.sv
// Directed testbench for the register rename stage.
// A reference model keeps the speculative map with ready bits, the committed
// map and the FIFO of free names, and every cycle's outputs are compared with it.
// Inputs change on the falling edge and outputs are sampled 1 ns later,
// well before the next rising edge.
`timescale 1ns/1ps

module rename_tb;

  localparam int CLK_PERIOD = 4;

  // Cycle budget of each phase, summed for the watchdog.
  localparam int RESET_CYCLES = 9;
  localparam int T1_CYCLES    = 18;  // Idle check, 16 reads, recover.
  localparam int T2_CYCLES    = 11;
  localparam int T3_CYCLES    = 6;
  localparam int T4_CYCLES    = 43;  // Recover, 32 fills, stall, 4 retires, 4 reuses.
  localparam int T5_CYCLES    = 38;
  localparam int TOTAL_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
                                T4_CYCLES + T5_CYCLES + 2;
  localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_PERIOD + 200;

  logic              clk;
  logic              rst;
  logic              dispatch_i;
  rename_pkg::areg_t opa_areg_i;
  rename_pkg::areg_t opb_areg_i;
  rename_pkg::areg_t dest_areg_i;
  logic              cdb_en_i;
  rename_pkg::preg_t cdb_preg_i;
  logic              retire_i;
  rename_pkg::areg_t retire_areg_i;
  rename_pkg::preg_t retire_preg_i;
  logic              recover_i;
  logic              stall_o;
  rename_pkg::preg_t new_preg_o;
  rename_pkg::preg_t opa_preg_o;
  rename_pkg::preg_t opb_preg_o;
  logic              opa_rdy_o;
  logic              opb_rdy_o;
  rename_pkg::preg_t old_preg_o;

  // Reference model.
  rename_pkg::preg_t spec_map [rename_pkg::NUM_AREG];  // Speculative map.
  logic              spec_rdy [rename_pkg::NUM_AREG];
  rename_pkg::preg_t com_map  [rename_pkg::NUM_AREG];  // Committed map.
  rename_pkg::preg_t free_q   [$];                     // Head is element 0.
  rename_pkg::areg_t rob_dest [$];                     // In-flight ops, oldest first.
  rename_pkg::preg_t rob_preg [$];

  int                error_count;
  int                check_count;
  int unsigned       seed_val;
  rename_pkg::preg_t last_opa;  // Outputs seen in the latest cycle.
  rename_pkg::preg_t last_opb;
  rename_pkg::preg_t last_old;
  rename_pkg::preg_t last_new;
  logic              last_opa_rdy;
  logic              last_opb_rdy;

  rename_stage UUT (
    .clk           (clk),
    .rst           (rst),
    .dispatch_i    (dispatch_i),
    .opa_areg_i    (opa_areg_i),
    .opb_areg_i    (opb_areg_i),
    .dest_areg_i   (dest_areg_i),
    .cdb_en_i      (cdb_en_i),
    .cdb_preg_i    (cdb_preg_i),
    .retire_i      (retire_i),
    .retire_areg_i (retire_areg_i),
    .retire_preg_i (retire_preg_i),
    .recover_i     (recover_i),
    .stall_o       (stall_o),
    .new_preg_o    (new_preg_o),
    .opa_preg_o    (opa_preg_o),
    .opb_preg_o    (opb_preg_o),
    .opa_rdy_o     (opa_rdy_o),
    .opb_rdy_o     (opb_rdy_o),
    .old_preg_o    (old_preg_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Ends a run that never reaches the verdict.
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic check_preg(input string name, input rename_pkg::preg_t got,
                            input rename_pkg::preg_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_rdy(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_stall(input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: stall_o = %b, expected %b", $time, got, exp);
    end
  endtask

  function automatic rename_pkg::areg_t pick_areg();
    return rename_pkg::areg_t'($urandom_range(rename_pkg::NUM_AREG - 1, 0));
  endfunction

  // Identity maps and names 32 to 63 free, as after reset.
  task automatic model_reset();
    free_q.delete();
    rob_dest.delete();
    rob_preg.delete();
    for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
      spec_map[i] = rename_pkg::preg_t'(i);
      spec_rdy[i] = 1'b1;
      com_map[i]  = rename_pkg::preg_t'(i);
      free_q.push_back(rename_pkg::preg_t'(rename_pkg::NUM_AREG + i));
    end
  endtask

  task automatic clear_strobes();
    dispatch_i = 1'b0;
    cdb_en_i   = 1'b0;
    retire_i   = 1'b0;
    recover_i  = 1'b0;
  endtask

  // One cycle with the given strobes. Checks outputs, then updates the model.
  task automatic run_cycle(input logic disp, input rename_pkg::areg_t a,
                           input rename_pkg::areg_t b, input rename_pkg::areg_t d,
                           input logic cdb, input rename_pkg::preg_t cp,
                           input logic ret, input logic rec);
    logic              accept;
    logic              exp_ra;
    logic              exp_rb;
    rename_pkg::preg_t exp_a;
    rename_pkg::preg_t exp_b;
    rename_pkg::preg_t exp_old;
    rename_pkg::preg_t exp_new;
    rename_pkg::areg_t ret_areg;
    rename_pkg::preg_t ret_preg;
    ret_areg = '0;
    ret_preg = '0;
    if (ret && (rob_dest.size() == 0)) begin
      error_count++;
      $display("Retire requested at %0t with no instruction in flight", $time);
      ret = 1'b0;
    end else if (ret) begin
      ret_areg = rob_dest[0];  // Oldest op retires first.
      ret_preg = rob_preg[0];
    end
    @(negedge clk);
    dispatch_i    = disp;
    opa_areg_i    = a;
    opb_areg_i    = b;
    dest_areg_i   = d;
    cdb_en_i      = cdb;
    cdb_preg_i    = cp;
    retire_i      = ret;
    retire_areg_i = ret_areg;
    retire_preg_i = ret_preg;
    recover_i     = rec;
    #1;
    accept  = disp && (free_q.size() != 0) && !rec;
    exp_a   = '0;
    exp_b   = '0;
    exp_old = '0;
    exp_new = '0;
    exp_ra  = 1'b0;
    exp_rb  = 1'b0;
    if (accept) begin
      exp_a   = spec_map[a];
      exp_b   = spec_map[b];
      exp_old = spec_map[d];
      exp_new = free_q[0];
      exp_ra  = spec_rdy[a] || (cdb && (cp == spec_map[a]));  // Same-cycle bypass.
      exp_rb  = spec_rdy[b] || (cdb && (cp == spec_map[b]));
    end
    check_stall(stall_o, free_q.size() == 0);
    check_preg("opa_preg_o", opa_preg_o, exp_a);
    check_preg("opb_preg_o", opb_preg_o, exp_b);
    check_preg("old_preg_o", old_preg_o, exp_old);
    check_preg("new_preg_o", new_preg_o, exp_new);
    check_rdy("opa_rdy_o", opa_rdy_o, exp_ra);
    check_rdy("opb_rdy_o", opb_rdy_o, exp_rb);
    last_opa     = opa_preg_o;
    last_opb     = opb_preg_o;
    last_old     = old_preg_o;
    last_new     = new_preg_o;
    last_opa_rdy = opa_rdy_o;
    last_opb_rdy = opb_rdy_o;
    @(posedge clk);
    if (rec) begin
      // Squashed names return ahead of the names that were still free.
      for (int i = rob_preg.size() - 1; i >= 0; i--) begin
        free_q.push_front(rob_preg[i]);
      end
      rob_dest.delete();
      rob_preg.delete();
      for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
        spec_map[i] = com_map[i];
        spec_rdy[i] = 1'b1;
      end
    end else begin
      if (cdb) begin
        for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
          if (spec_map[i] == cp) spec_rdy[i] = 1'b1;
        end
      end
      if (accept) begin  // Applied after the CDB so dispatch wins.
        spec_map[d] = exp_new;
        spec_rdy[d] = 1'b0;
        void'(free_q.pop_front());
        rob_dest.push_back(d);
        rob_preg.push_back(exp_new);
      end
      if (ret) begin
        free_q.push_back(com_map[ret_areg]);  // Old committed name is freed.
        com_map[ret_areg] = ret_preg;
        void'(rob_dest.pop_front());
        void'(rob_preg.pop_front());
      end
    end
  endtask

  task automatic dispatch_op(input rename_pkg::areg_t a, input rename_pkg::areg_t b,
                             input rename_pkg::areg_t d);
    run_cycle(1'b1, a, b, d, 1'b0, '0, 1'b0, 1'b0);
  endtask

  task automatic retire_oldest();
    run_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b1, 1'b0);
  endtask

  task automatic recover_all();
    run_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b1);
  endtask

  // Quiet cycle, checks stall and that dispatch outputs read zero.
  task automatic check_idle(input logic exp_stall);
    @(negedge clk);
    clear_strobes();
    #1;
    check_stall(stall_o, exp_stall);
    check_preg("new_preg_o", new_preg_o, '0);
    check_preg("opa_preg_o", opa_preg_o, '0);
    check_preg("old_preg_o", old_preg_o, '0);
    check_rdy("opa_rdy_o", opa_rdy_o, 1'b0);
  endtask

  task automatic test_reset_state();
    check_idle(1'b0);
    for (int i = 0; i < rename_pkg::NUM_AREG / 2; i++) begin
      // Destination equals operand A, which is never read again here.
      dispatch_op(rename_pkg::areg_t'(2 * i), rename_pkg::areg_t'(2 * i + 1),
                  rename_pkg::areg_t'(2 * i));
      check_preg("opa_preg_o", last_opa, rename_pkg::preg_t'(2 * i));
      check_preg("opb_preg_o", last_opb, rename_pkg::preg_t'(2 * i + 1));
      check_rdy("opa_rdy_o", last_opa_rdy, 1'b1);
      check_rdy("opb_rdy_o", last_opb_rdy, 1'b1);
    end
    recover_all();
  endtask

  task automatic test_renaming();
    rename_pkg::preg_t fresh;
    for (int k = 0; k < 8; k++) begin
      dispatch_op(pick_areg(), pick_areg(), pick_areg());
      check_preg("new_preg_o", last_new, rename_pkg::preg_t'(rename_pkg::NUM_AREG + k));
    end
    dispatch_op(5'd0, 5'd0, 5'd9);
    fresh = last_new;
    dispatch_op(5'd9, 5'd9, 5'd10);  // Reads the name just given to r9.
    check_preg("opa_preg_o", last_opa, fresh);
    check_rdy("opa_rdy_o", last_opa_rdy, 1'b0);
    dispatch_op(5'd1, 5'd1, 5'd9);
    check_preg("old_preg_o", last_old, fresh);
  endtask

  task automatic test_cdb();
    run_cycle(1'b1, 5'd9, 5'd0, 5'd11, 1'b1, spec_map[9], 1'b0, 1'b0);
    check_rdy("opa_rdy_o", last_opa_rdy, 1'b1);  // Bypassed in the broadcast cycle.
    dispatch_op(5'd9, 5'd9, 5'd0);  // Leaves r0 waiting.
    check_rdy("opa_rdy_o", last_opa_rdy, 1'b1);
    // Tail of the free list is mapped nowhere.
    run_cycle(1'b0, '0, '0, '0, 1'b1, free_q[$], 1'b0, 1'b0);
    dispatch_op(5'd0, 5'd10, 5'd13);
    check_rdy("opa_rdy_o", last_opa_rdy, 1'b0);  // Entry 0 still waits.
    check_rdy("opb_rdy_o", last_opb_rdy, 1'b0);
    run_cycle(1'b1, 5'd0, 5'd0, 5'd12, 1'b1, spec_map[12], 1'b0, 1'b0);
    dispatch_op(5'd12, 5'd12, 5'd14);
    check_rdy("opa_rdy_o", last_opa_rdy, 1'b0);  // Dispatch beat the CDB set.
  endtask

  task automatic test_exhaustion();
    rename_pkg::preg_t rel_q [$];
    recover_all();
    for (int k = 0; k < rename_pkg::FREE_DEPTH; k++) begin
      dispatch_op(pick_areg(), pick_areg(), pick_areg());
    end
    check_idle(1'b1);
    dispatch_op(5'd3, 5'd4, 5'd5);  // Stalled, no mapping changes.
    check_preg("new_preg_o", last_new, '0);
    for (int k = 0; k < 4; k++) begin
      rel_q.push_back(com_map[rob_dest[0]]);
      retire_oldest();
    end
    for (int k = 0; k < 4; k++) begin
      dispatch_op(5'd5, pick_areg(), pick_areg());
      check_preg("new_preg_o", last_new, rel_q[k]);
    end
  endtask

  task automatic test_recovery();
    rename_pkg::preg_t restored [$];
    recover_all();
    for (int k = 0; k < 20; k++) begin
      if (($urandom_range(2, 0) == 0) && (rob_dest.size() != 0)) begin
        retire_oldest();
      end else begin
        run_cycle(1'b1, pick_areg(), pick_areg(), pick_areg(), 1'b1,
                  spec_map[pick_areg()], 1'b0, 1'b0);
      end
    end
    // Dispatch and CDB in the recover cycle are dropped.
    run_cycle(1'b1, 5'd1, 5'd2, 5'd3, 1'b1, spec_map[3], 1'b0, 1'b1);
    restored = free_q;
    for (int i = 0; i < rename_pkg::NUM_AREG / 2; i++) begin
      dispatch_op(rename_pkg::areg_t'(2 * i), rename_pkg::areg_t'(2 * i + 1),
                  rename_pkg::areg_t'(2 * i));
      check_preg("opa_preg_o", last_opa, com_map[2 * i]);
      check_preg("opb_preg_o", last_opb, com_map[2 * i + 1]);
      check_rdy("opa_rdy_o", last_opa_rdy, 1'b1);
      check_rdy("opb_rdy_o", last_opb_rdy, 1'b1);
      check_preg("new_preg_o", last_new, restored[i]);
    end
  endtask

  initial begin
    rst           = 1'b1;
    opa_areg_i    = '0;
    opb_areg_i    = '0;
    dest_areg_i   = '0;
    cdb_preg_i    = '0;
    retire_areg_i = '0;
    retire_preg_i = '0;
    clear_strobes();
    error_count = 0;
    check_count = 0;
    seed_val    = $urandom(7);
    model_reset();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_renaming();
    test_cdb();
    test_exhaustion();
    test_recovery();
    check_idle(free_q.size() == 0);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
logic/rename_pkg.sv
logic/free_if.sv
logic/map_table.sv
logic/free_list.sv
logic/arch_map.sv
logic/rename_stage.sv
bench/rename_assert.sv
bench/rename_tb.sv

// File: logic/arch_map.sv
// Retirement map holding the committed architectural state.
// On retire it records the new name of the retiring destination and frees
// the name it replaces by pushing it onto the free list.
// The whole map is the checkpoint that the map table loads on recovery.
`timescale 1ns/1ps

module arch_map (
  input  logic              clk,
  input  logic              rst,
  input  logic              retire_i,       // One-cycle retire strobe.
  input  rename_pkg::areg_t retire_areg_i,  // Destination of the retiring op.
  input  rename_pkg::preg_t retire_preg_i,  // Name it was renamed to.
  output rename_pkg::amap_t ckpt_o,         // Recovery checkpoint.
  free_if.releaser          free_o
);

  rename_pkg::amap_t arch_q;  // Committed mapping.

  assign ckpt_o = arch_q;

  // The committed name being overwritten has no reader left once the
  // retiring instruction commits, so it goes back to the free list.
  assign free_o.release_en   = retire_i;
  assign free_o.release_preg = arch_q[retire_areg_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
        arch_q[i] <= rename_pkg::preg_t'(i);  // Identity, as in map_table.
      end
    end else if (retire_i) begin
      arch_q[retire_areg_i] <= retire_preg_i;
    end
  end

endmodule

// File: logic/free_if.sv
// Bundle between the free list and the blocks around it.
// The map table pops names through the alloc side, and the retirement map
// pushes old names back through the releaser side.
// A pop happens at the clock edge of a cycle with alloc_en high, and a push
// at the edge of a cycle with release_en high. Both may occur together.
`timescale 1ns/1ps

interface free_if;

  // Allocation side.
  logic              alloc_en;      // Pop the head at the next edge.
  rename_pkg::preg_t alloc_preg;    // Head entry of the list.
  logic              empty;         // No name left to hand out.

  // Release side.
  logic              release_en;    // Push release_preg at the next edge.
  rename_pkg::preg_t release_preg;  // Name freed by a retiring instruction.

  // The free list itself.
  modport list (
    input  alloc_en,
    output alloc_preg,
    output empty,
    input  release_en,
    input  release_preg
  );

  // Map table takes names at dispatch.
  modport alloc (
    output alloc_en,
    input  alloc_preg,
    input  empty
  );

  // Retirement map gives names back.
  modport releaser (
    output release_en,
    output release_preg
  );

endinterface

// File: logic/free_list.sv
// Circular FIFO of physical register names that are not in use.
// The map table pops the head on dispatch and the retirement map pushes
// old names at the tail on retire.
// Recovery rewinds the head to the tail, which makes the list full again.
// This holds because retirement is in order, so every name popped since the
// last push belongs to a squashed instruction.
`timescale 1ns/1ps

module free_list (
  input  logic   clk,
  input  logic   rst,
  input  logic   recover_i,  // Rewind to full.
  free_if.list   free_o
);

  localparam int PTR_W = $clog2(rename_pkg::FREE_DEPTH);

  // Count reaches FREE_DEPTH, so it is one bit wider than a pointer.
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(rename_pkg::FREE_DEPTH);

  rename_pkg::preg_t fifo_q [rename_pkg::FREE_DEPTH];  // Name storage.
  logic [PTR_W-1:0]  head_q;   // Next name to hand out.
  logic [PTR_W-1:0]  tail_q;   // Next slot to fill.
  logic [PTR_W:0]    count_q;  // Names currently held.

  logic push;
  logic pop;

  // Step a pointer with wrap at the end of the buffer.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(rename_pkg::FREE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push = free_o.release_en;
  assign pop  = free_o.alloc_en;  // Already gated by empty in map_table.

  assign free_o.empty      = (count_q == '0);
  assign free_o.alloc_preg = fifo_q[head_q];  // Valid while not empty.

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= FULL_CNT;
      // Names above the architectural range start out free, in order.
      for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
        fifo_q[i] <= rename_pkg::preg_t'(rename_pkg::NUM_AREG + i);
      end
    end else if (recover_i) begin
      head_q  <= tail_q;    // Squashed names come back in their old order.
      count_q <= FULL_CNT;
    end else begin
      if (push) begin
        fifo_q[tail_q] <= free_o.release_preg;
        tail_q         <= next_ptr(tail_q);
      end
      if (pop) begin
        head_q <= next_ptr(head_q);
      end
      // Push and pop together leave the count alone.
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: logic/map_table.sv
// Speculative register map of the rename stage.
// Dispatch reads both operand names with their ready bits and the old
// destination name in the same cycle, then writes the new name at the edge.
// A CDB broadcast sets the ready bit of the entry holding that name.
// Recovery reloads the map from the retirement checkpoint, all entries ready.
`timescale 1ns/1ps

module map_table (
  input  logic              clk,
  input  logic              rst,
  input  logic              dispatch_i,   // One-cycle dispatch strobe.
  input  rename_pkg::areg_t opa_areg_i,   // Source register A.
  input  rename_pkg::areg_t opb_areg_i,   // Source register B.
  input  rename_pkg::areg_t dest_areg_i,  // Destination register.
  input  logic              cdb_en_i,     // CDB broadcast strobe.
  input  rename_pkg::preg_t cdb_preg_i,   // Name being broadcast.
  input  logic              recover_i,    // Restore from the checkpoint.
  input  rename_pkg::amap_t ckpt_i,       // Committed map from arch_map.
  free_if.alloc             free_o,
  output rename_pkg::preg_t opa_preg_o,
  output rename_pkg::preg_t opb_preg_o,
  output rename_pkg::preg_t old_preg_o,   // Previous name of the destination.
  output rename_pkg::preg_t new_preg_o,   // Name allocated to the destination.
  output logic              opa_rdy_o,
  output logic              opb_rdy_o
);

  rename_pkg::amap_t               map_q;  // Current speculative mapping.
  logic [rename_pkg::NUM_AREG-1:0] rdy_q;  // One ready bit per entry.

  logic              dispatch_ok;  // Dispatch accepted this cycle.
  logic              cdb_hit;      // Broadcast name found in the map.
  rename_pkg::areg_t cdb_idx;      // Entry holding the broadcast name.
  logic              opa_bypass;
  logic              opb_bypass;

  // A dispatch needs a free name, and recovery squashes it.
  assign dispatch_ok = dispatch_i && !free_o.empty && !recover_i;
  assign free_o.alloc_en = dispatch_ok;  // Pops the head at the edge.

  // Same-cycle broadcast counts as ready, matched by physical name.
  assign opa_bypass = cdb_en_i && (cdb_preg_i == map_q[opa_areg_i]);
  assign opb_bypass = cdb_en_i && (cdb_preg_i == map_q[opb_areg_i]);

  // Dispatch outputs read zero unless the dispatch is taken.
  always_comb begin
    opa_preg_o = '0;
    opb_preg_o = '0;
    old_preg_o = '0;
    new_preg_o = '0;
    opa_rdy_o  = 1'b0;
    opb_rdy_o  = 1'b0;
    if (dispatch_ok) begin
      opa_preg_o = map_q[opa_areg_i];
      opb_preg_o = map_q[opb_areg_i];
      old_preg_o = map_q[dest_areg_i];   // Goes to the ROB for later release.
      new_preg_o = free_o.alloc_preg;    // Head of the free list.
      opa_rdy_o  = rdy_q[opa_areg_i] || opa_bypass;
      opb_rdy_o  = rdy_q[opb_areg_i] || opb_bypass;
    end
  end

  // Find the entry that holds the broadcast name.
  // At most one entry maps any given physical name.
  always_comb begin
    cdb_hit = 1'b0;
    cdb_idx = '0;
    for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
      if (!cdb_hit && (map_q[i] == cdb_preg_i)) begin
        cdb_hit = 1'b1;
        cdb_idx = rename_pkg::areg_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity map, everything ready.
      for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
        map_q[i] <= rename_pkg::preg_t'(i);
      end
      rdy_q <= '1;
    end else if (recover_i) begin
      map_q <= ckpt_i;  // Committed values are all produced.
      rdy_q <= '1;
    end else begin
      if (cdb_en_i && cdb_hit) begin
        rdy_q[cdb_idx] <= 1'b1;
      end
      // Placed last so a dispatch to the same entry overrides the CDB set.
      if (dispatch_ok) begin
        map_q[dest_areg_i] <= free_o.alloc_preg;
        rdy_q[dest_areg_i] <= 1'b0;  // Waits for its producer.
      end
    end
  end

endmodule

// File: logic/rename_pkg.sv
// Shared sizes and index types for the register rename stage.
// Every block of the stage refers to these by scoped name, so the register
// counts are set in exactly one spot.
// The stage follows an R10000 style with a separate physical register file.

package rename_pkg;

  // Architectural registers seen by the ISA.
  localparam int NUM_AREG = 32;

  // Physical registers in the shared register file.
  localparam int NUM_PREG = 64;

  // Names not held by the committed map sit in the free list.
  localparam int FREE_DEPTH = NUM_PREG - NUM_AREG;

  // Index widths derived from the counts above.
  localparam int AREG_W = $clog2(NUM_AREG);
  localparam int PREG_W = $clog2(NUM_PREG);

  // Architectural register index, 5 bits.
  typedef logic [AREG_W-1:0] areg_t;

  // Physical register name, 6 bits.
  typedef logic [PREG_W-1:0] preg_t;

  // A whole map, one physical name per architectural register.
  // Entry i is the name that register i currently points at.
  // The retirement map hands one of these to the map table on recovery.
  typedef preg_t [NUM_AREG-1:0] amap_t;

endpackage

// File: logic/rename_stage.sv
// Top level of the register rename stage.
// Connects the speculative map table, the free list and the retirement map.
// Decode, the CDB, the ROB and the recovery source sit outside and drive the
// plain strobes and indices below.
// stall_o is high while no physical register is free. Dispatch is then ignored.
`timescale 1ns/1ps

module rename_stage (
  input  logic              clk,
  input  logic              rst,
  // Dispatch from decode.
  input  logic              dispatch_i,
  input  rename_pkg::areg_t opa_areg_i,
  input  rename_pkg::areg_t opb_areg_i,
  input  rename_pkg::areg_t dest_areg_i,
  // Result broadcast.
  input  logic              cdb_en_i,
  input  rename_pkg::preg_t cdb_preg_i,
  // Retire from the ROB.
  input  logic              retire_i,
  input  rename_pkg::areg_t retire_areg_i,
  input  rename_pkg::preg_t retire_preg_i,
  // Mispredict recovery.
  input  logic              recover_i,
  // Back to decode.
  output logic              stall_o,
  // To the reservation stations and the ROB.
  output rename_pkg::preg_t new_preg_o,
  output rename_pkg::preg_t opa_preg_o,
  output rename_pkg::preg_t opb_preg_o,
  output logic              opa_rdy_o,
  output logic              opb_rdy_o,
  output rename_pkg::preg_t old_preg_o
);

  free_if            free_bus ();  // Free list traffic.
  rename_pkg::amap_t ckpt;         // Committed map for recovery.

  assign stall_o = free_bus.empty;

  map_table u_map_table (
    .clk         (clk),
    .rst         (rst),
    .dispatch_i  (dispatch_i),
    .opa_areg_i  (opa_areg_i),
    .opb_areg_i  (opb_areg_i),
    .dest_areg_i (dest_areg_i),
    .cdb_en_i    (cdb_en_i),
    .cdb_preg_i  (cdb_preg_i),
    .recover_i   (recover_i),
    .ckpt_i      (ckpt),
    .free_o      (free_bus.alloc),
    .opa_preg_o  (opa_preg_o),
    .opb_preg_o  (opb_preg_o),
    .old_preg_o  (old_preg_o),
    .new_preg_o  (new_preg_o),
    .opa_rdy_o   (opa_rdy_o),
    .opb_rdy_o   (opb_rdy_o)
  );

  free_list u_free_list (
    .clk       (clk),
    .rst       (rst),
    .recover_i (recover_i),
    .free_o    (free_bus.list)
  );

  arch_map u_arch_map (
    .clk           (clk),
    .rst           (rst),
    .retire_i      (retire_i),
    .retire_areg_i (retire_areg_i),
    .retire_preg_i (retire_preg_i),
    .ckpt_o        (ckpt),
    .free_o        (free_bus.releaser)
  );

endmodule
